/* Makefile */
.PHONY: all compile run clean

all: run

compile: obj_dir/Vtb_alu_cluster

obj_dir/Vtb_alu_cluster: vlog.f $(wildcard rtl/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_alu_cluster -f vlog.f

# a simulator that exits with an error also counts as a failure
run: compile
	./obj_dir/Vtb_alu_cluster > sim.log 2>&1 || echo "Something failed" >> sim.log
	cat sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* rtl/alu_cluster_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_cluster_top
	import ooo_pkg::*;
#(
	parameter int rs_size = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              flush,

	input  logic [1:0]        dispatch_valid,
	input  dispatch_t [1:0]   dispatch,
	output logic [1:0]        free,

	input  cdb_packet_t       ext_cdb,
	output cdb_packet_t       result
);

	localparam int idx_w = $clog2(rs_size);

	rs_entry_t [rs_size-1:0] entries;
	logic                    issue_valid;
	logic [idx_w-1:0]        issue_index;
	rs_entry_t               issued;
	cdb_packet_t             alu_cdb;
	cdb_packet_t [1:0]       cdb;

	// lane 0 is the local ALU, lane 1 the outside units
	assign cdb[0] = alu_cdb;
	assign cdb[1] = ext_cdb;
	assign result = alu_cdb;

	assign issued = entries[issue_index];

	alu_rs #(
		.rs_size (rs_size)
	) u_rs (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.free           (free),
		.cdb            (cdb),
		.issue_valid    (issue_valid),
		.issue_index    (issue_index),
		.entries        (entries)
	);

	rs_select #(
		.rs_size (rs_size)
	) u_select (
		.entries     (entries),
		.issue_valid (issue_valid),
		.issue_index (issue_index)
	);

	alu_exec u_exec (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush       (flush),
		.issue_valid (issue_valid),
		.issued      (issued),
		.result      (alu_cdb)
	);

endmodule

`default_nettype wire

/* rtl/alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec
	import ooo_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush,

	input  logic        issue_valid,
	input  rs_entry_t   issued,

	output cdb_packet_t result
);

	word_t    a;
	word_t    b;
	word_t    value_n;
	logic     valid_q;
	rob_tag_t tag_q;
	word_t    value_q;

	assign a = issued.src[0].value;
	assign b = issued.src[1].value;

	always_comb begin
		unique case (issued.op)
			alu_add: value_n = a + b;
			alu_sub: value_n = a - b;
			alu_and: value_n = a & b;
			alu_or:  value_n = a | b;
			alu_xor: value_n = a ^ b;
			// shift amount from the low five bits
			alu_sll: value_n = a << b[4:0];
			alu_srl: value_n = a >> b[4:0];
			alu_slt: value_n = word_t'($signed(a) < $signed(b));
			default: value_n = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= issue_valid && !flush;
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			tag_q   <= issued.dest;
			value_q <= value_n;
		end
	end

	assign result = '{valid: valid_q, tag: tag_q, value: value_q};

	// back-to-back results come from two different entries
	a_result_strobe: assert property (
		@(posedge clk) disable iff (!rst_n)
		result.valid && $past(result.valid) |-> result.tag != $past(result.tag)
	);

endmodule

`default_nettype wire

/* rtl/alu_rs.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_rs
	import ooo_pkg::*;
#(
	parameter int rs_size = 8
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,

	input  logic [1:0]                   dispatch_valid,
	input  dispatch_t [1:0]              dispatch,
	output logic [1:0]                   free,

	input  cdb_packet_t [1:0]            cdb,

	input  logic                         issue_valid,
	input  logic [$clog2(rs_size)-1:0]   issue_index,

	output rs_entry_t [rs_size-1:0]      entries
);

	localparam int idx_w = $clog2(rs_size);

	rs_entry_t [rs_size-1:0] entries_q;
	rs_entry_t [rs_size-1:0] captured;
	rs_entry_t [rs_size-1:0] entries_n;

	rs_entry_t [1:0] disp_entry;
	rs_entry_t [1:0] disp_captured;

	logic [1:0]            free_q;
	logic [1:0]            free_n;
	logic [1:0][idx_w-1:0] slot_q;
	logic [1:0][idx_w-1:0] slot_n;

	assign entries = entries_q;
	assign free    = free_q;

	// wakeup of stored entries
	for (genvar i = 0; i < rs_size; i++) begin : gen_entry_capture
		operand_capture u_capture (
			.entry_in  (entries_q[i]),
			.cdb       (cdb),
			.entry_out (captured[i])
		);
	end

	// incoming ops also see this cycle's broadcasts
	for (genvar k = 0; k < 2; k++) begin : gen_dispatch_capture
		assign disp_entry[k] = '{
			busy: 1'b1,
			op:   dispatch[k].op,
			dest: dispatch[k].dest,
			src:  dispatch[k].src
		};

		operand_capture u_capture (
			.entry_in  (disp_entry[k]),
			.cdb       (cdb),
			.entry_out (disp_captured[k])
		);
	end

	always_comb begin
		entries_n = captured;

		// pop the issued entry
		if (issue_valid)
			entries_n[issue_index] = '0;

		// push dispatched ops
		for (int k = 0; k < 2; k++) begin
			if (dispatch_valid[k])
				entries_n[slot_q[k]] = disp_captured[k];
		end
	end

	// free slot search on the next state, highest index for lane 0
	always_comb begin
		free_n = '0;
		slot_n = '0;
		for (int i = 0; i < rs_size; i++) begin
			if (!entries_n[i].busy) begin
				free_n[0] = 1'b1;
				slot_n[0] = idx_w'(i);
			end
		end
		for (int i = 0; i < rs_size; i++) begin
			if (!entries_n[i].busy && idx_w'(i) != slot_n[0]) begin
				free_n[1] = 1'b1;
				slot_n[1] = idx_w'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			entries_q <= '0;
			free_q    <= 2'b11;
			slot_q[0] <= idx_w'(rs_size - 1);
			slot_q[1] <= idx_w'(rs_size - 2);
		end else if (flush) begin
			entries_q <= '0;
			free_q    <= 2'b11;
			slot_q[0] <= idx_w'(rs_size - 1);
			slot_q[1] <= idx_w'(rs_size - 2);
		end else begin
			entries_q <= entries_n;
			free_q    <= free_n;
			slot_q    <= slot_n;
		end
	end

	// dispatcher must honour the free flags
	a_dispatch_free: assert property (
		@(posedge clk) disable iff (!rst_n)
		(dispatch_valid & ~free_q) == 2'b00
	);

	// selector only picks occupied entries
	a_issue_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		issue_valid |-> entries_q[issue_index].busy
	);

endmodule

`default_nettype wire

/* rtl/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

	// datapath and tag widths
	parameter int xlen      = 32;
	parameter int rob_idx_w = 5;

	typedef logic [xlen-1:0]      word_t;
	typedef logic [rob_idx_w-1:0] rob_tag_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_slt
	} alu_op_t;

	// source operand, either a value or the tag of its producer
	typedef struct packed {
		logic     ready;
		rob_tag_t tag;
		word_t    value;
	} operand_t;

	typedef struct packed {
		logic              busy;
		alu_op_t           op;
		rob_tag_t          dest;
		operand_t [1:0]    src;
	} rs_entry_t;

	// one dispatch lane, slot is chosen inside the station
	typedef struct packed {
		alu_op_t        op;
		rob_tag_t       dest;
		operand_t [1:0] src;
	} dispatch_t;

	// result broadcast
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		word_t    value;
	} cdb_packet_t;

endpackage

`default_nettype wire

/* rtl/operand_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_capture
	import ooo_pkg::*;
(
	input  rs_entry_t         entry_in,
	input  cdb_packet_t [1:0] cdb,
	output rs_entry_t         entry_out
);

	always_comb begin
		entry_out = entry_in;
		for (int s = 0; s < 2; s++) begin
			for (int l = 0; l < 2; l++) begin
				// only waiting operands pick up a broadcast
				if (!entry_out.src[s].ready && cdb[l].valid &&
				    cdb[l].tag == entry_in.src[s].tag) begin
					entry_out.src[s].value = cdb[l].value;
					entry_out.src[s].ready = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/rs_select.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_select
	import ooo_pkg::*;
#(
	parameter int rs_size = 8
) (
	input  rs_entry_t [rs_size-1:0]      entries,
	output logic                         issue_valid,
	output logic [$clog2(rs_size)-1:0]   issue_index
);

	localparam int idx_w = $clog2(rs_size);

	logic [rs_size-1:0] ready;

	for (genvar i = 0; i < rs_size; i++) begin : gen_ready
		assign ready[i] = entries[i].busy &&
		                  entries[i].src[0].ready &&
		                  entries[i].src[1].ready;
	end

	// walk down so the lowest ready index wins
	always_comb begin
		issue_valid = 1'b0;
		issue_index = '0;
		for (int i = rs_size - 1; i >= 0; i--) begin
			if (ready[i]) begin
				issue_valid = 1'b1;
				issue_index = idx_w'(i);
			end
		end

		// pick is the lowest set bit of the ready vector
		a_issue_ready: assert ((ready & (~ready + 1'b1)) ==
		                       (issue_valid ? (rs_size'(1) << issue_index) : '0));
	end

endmodule

`default_nettype wire

/* test/tb_alu_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_alu_cluster
	import ooo_pkg::*;
();

	localparam int rs_size    = 8;
	localparam int n_tags     = 1 << rob_idx_w;
	localparam int total_ops  = 32 + 16 + 6 + 8 + 16 + 200;
	localparam int max_cycles = total_ops * 20 + 500;

	// tag life cycle in the scoreboard
	localparam int st_free = 0;
	localparam int st_pend = 1;
	localparam int st_ext  = 2;
	localparam int st_done = 3;

	logic            clk;
	logic            rst_n;
	logic            flush;
	logic [1:0]      dispatch_valid;
	dispatch_t [1:0] dispatch;
	logic [1:0]      free;
	cdb_packet_t     ext_cdb;
	cdb_packet_t     result;
	cdb_packet_t     exp_pkt;
	int              exp_tag;

	logic [31:0] rng = 32'h584b783e;
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	int          failed_tests = 0;
	int          n_pend = 0;
	int          n_done = 0;
	int          tag_ptr = 0;
	int          tag_state [n_tags];
	word_t       exp_val [n_tags];
	int          disp_cyc [n_tags];
	bit          lat_chk [n_tags];
	int          recent [$];
	int          ext_tags [$];

	alu_cluster_top #(
		.rs_size (rs_size)
	) i_alu_cluster_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.free           (free),
		.ext_cdb        (ext_cdb),
		.result         (result)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic alu_op_t random_op();
		return alu_op_t'(3'(next_rand()));
	endfunction

	function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or:  return a | b;
			alu_xor: return a ^ b;
			alu_sll: return a << b[4:0];
			alu_srl: return a >> b[4:0];
			alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	task automatic check_cdb(input cdb_packet_t got, input cdb_packet_t exp);
		checks++;
		if (got.tag !== exp.tag) begin
			$display("MISMATCH t=%0t result.tag got %0d exp %0d", $time, got.tag, exp.tag);
			errors++;
		end
		if (got.value !== exp.value) begin
			$display("MISMATCH t=%0t result.value got %h exp %h", $time, got.value, exp.value);
			errors++;
		end
	endtask

	task automatic check_free(input logic [1:0] got, input logic [1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH t=%0t free got %b exp %b", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			$display("ERROR t=%0t: %s, %0d results seen instead of %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// round robin over completed or unused tags
	function automatic int alloc_tag();
		int t;
		for (int i = 0; i < n_tags; i++) begin
			t = (tag_ptr + i) % n_tags;
			if (tag_state[t] == st_free || tag_state[t] == st_done) begin
				tag_ptr = (t + 1) % n_tags;
				return t;
			end
		end
		return -1;
	endfunction

	// with a single op in flight the expected tag is known up front
	function automatic int sole_pending();
		if (n_pend != 1)
			return -1;
		for (int i = 0; i < n_tags; i++) begin
			if (tag_state[i] == st_pend)
				return i;
		end
		return -1;
	endfunction

	function automatic int new_ext();
		int t;
		t = alloc_tag();
		if (t >= 0) begin
			tag_state[t] = st_ext;
			exp_val[t] = next_rand();
		end
		return t;
	endfunction

	function automatic int pick_dep();
		if (recent.size() == 0 || (next_rand() & 32'd1) == 0)
			return -1;
		return recent[next_rand() % recent.size()];
	endfunction

	// known producers are resolved here, others are left waiting on their tag
	function automatic operand_t make_src(input int dep, input word_t v);
		operand_t o;
		if (dep < 0 || tag_state[dep] == st_free)
			o = '{ready: 1'b1, tag: '0, value: v};
		else if (tag_state[dep] == st_done)
			o = '{ready: 1'b1, tag: '0, value: exp_val[dep]};
		else
			o = '{ready: 1'b0, tag: rob_tag_t'(dep), value: next_rand()};
		return o;
	endfunction

	task automatic send_op(input int lane, input alu_op_t op, input int dep_a,
	                       input int dep_b, input bit chk, output int tag);
		operand_t a;
		operand_t b;
		tag = alloc_tag();
		if (tag < 0)
			return;
		a = make_src(dep_a, next_rand());
		b = make_src(dep_b, next_rand());
		exp_val[tag] = alu_ref(op, a.ready ? a.value : exp_val[dep_a],
		                       b.ready ? b.value : exp_val[dep_b]);
		tag_state[tag] = st_pend;
		disp_cyc[tag] = cyc;
		lat_chk[tag] = chk;
		n_pend++;
		dispatch_valid[lane] = 1'b1;
		dispatch[lane].op = op;
		dispatch[lane].dest = rob_tag_t'(tag);
		dispatch[lane].src[0] = a;
		dispatch[lane].src[1] = b;
		recent.push_back(tag);
		if (recent.size() > 6)
			void'(recent.pop_front());
	endtask

	task automatic send_ext(input int tag);
		ext_cdb.valid = 1'b1;
		ext_cdb.tag = rob_tag_t'(tag);
		ext_cdb.value = exp_val[tag];
		tag_state[tag] = st_done;
	endtask

	task automatic step();
		@(posedge clk);
		#1;
		dispatch_valid = '0;
		ext_cdb.valid = 1'b0;
		flush = 1'b0;
	endtask

	task automatic wait_idle();
		while (n_pend > 0)
			step();
		repeat (2) step();
	endtask

	task automatic fill_station(input int x);
		int n;
		int t;
		n = 0;
		while (n < rs_size) begin
			step();
			for (int k = 0; k < 2; k++) begin
				if (free[k] && n < rs_size) begin
					send_op(k, random_op(), x, (next_rand() & 32'd1) ? x : -1, 1'b0, t);
					n++;
				end
			end
		end
		step();
		check_free(free, 2'b00);
	endtask

	task automatic end_test(input int num, input string name, input int err0);
		if (errors == err0) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			$display("test %0d %s: FAIL with %0d errors", num, name, errors - err0);
			failed_tests++;
		end
	endtask

	// results complete out of order, so look them up by tag
	always @(negedge clk) begin
		if (rst_n && result.valid) begin
			exp_tag = sole_pending();
			if (exp_tag < 0 && tag_state[result.tag] == st_pend)
				exp_tag = result.tag;
			if (exp_tag < 0) begin
				$display("ERROR t=%0t: result for tag %0d that is not outstanding",
				         $time, result.tag);
				errors++;
			end else begin
				exp_pkt = '{valid: 1'b1, tag: rob_tag_t'(exp_tag),
				            value: exp_val[exp_tag]};
				check_cdb(result, exp_pkt);
				if (lat_chk[exp_tag] && cyc - disp_cyc[exp_tag] != 2) begin
					$display("ERROR t=%0t: tag %0d finished %0d cycles after dispatch, not 2",
					         $time, exp_tag, cyc - disp_cyc[exp_tag]);
					errors++;
				end
				tag_state[exp_tag] = st_done;
				n_pend--;
				n_done++;
			end
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		int t;
		int t0;
		int p0;
		int p1;
		int x;
		int n;
		int err0;
		int done0;
		clk = 1'b0;
		rst_n = 1'b0;
		flush = 1'b0;
		dispatch_valid = '0;
		dispatch = '0;
		ext_cdb = '0;
		for (int i = 0; i < n_tags; i++) begin
			tag_state[i] = st_free;
			exp_val[i] = '0;
			disp_cyc[i] = 0;
			lat_chk[i] = 1'b0;
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// each op alone on lane 0, alone on lane 1, then on both lanes
		err0 = errors;
		for (int i = 0; i < 8; i++) begin
			for (int k = 0; k < 2; k++) begin
				step();
				check_free(free, 2'b11);
				send_op(k, alu_op_t'(i), -1, -1, 1'b1, t);
				wait_idle();
			end
			step();
			send_op(0, alu_op_t'(i), -1, -1, 1'b0, t);
			send_op(1, alu_op_t'(i), -1, -1, 1'b0, t);
			wait_idle();
		end
		end_test(1, "independent ops", err0);

		err0 = errors;
		for (int c = 0; c < 4; c++) begin
			p0 = -1;
			p1 = -1;
			for (int i = 0; i < 2; i++) begin
				step();
				send_op(0, random_op(), p0, p1, 1'b0, t0);
				send_op(1, random_op(), t0, p0, 1'b0, t);
				p0 = t;
				p1 = t0;
			end
			wait_idle();
		end
		end_test(2, "dependency chains", err0);

		err0 = errors;
		x = new_ext();
		step();
		send_op(0, random_op(), x, -1, 1'b0, t);
		step();
		send_op(1, random_op(), -1, x, 1'b0, t);
		done0 = n_done;
		repeat (4) step();
		check_count(n_done, done0, "ops finished before their external operand");
		// consumer dispatched in the broadcast cycle
		send_op(0, random_op(), x, x, 1'b0, t);
		send_ext(x);
		step();
		x = new_ext();
		send_op(0, random_op(), -1, -1, 1'b0, t0);
		send_op(1, random_op(), t0, x, 1'b0, t);
		repeat (2) step();
		send_ext(x);
		step();
		x = new_ext();
		send_op(1, random_op(), x, x, 1'b0, t);
		send_ext(x);
		wait_idle();
		end_test(3, "external wakeup", err0);

		err0 = errors;
		x = new_ext();
		done0 = n_done;
		fill_station(x);
		repeat (10) step();
		check_count(n_done, done0, "ops finished while their tag was never sent");
		send_ext(x);
		wait_idle();
		check_free(free, 2'b11);
		check_count(n_done, done0 + rs_size, "full station after the wakeup");
		end_test(4, "full station", err0);

		err0 = errors;
		x = new_ext();
		fill_station(x);
		flush = 1'b1;
		for (int i = 0; i < n_tags; i++) begin
			if (tag_state[i] == st_pend || tag_state[i] == st_ext)
				tag_state[i] = st_free;
		end
		n_pend = 0;
		step();
		check_free(free, 2'b11);
		repeat (10) step();
		done0 = n_done;
		n = 0;
		while (n < rs_size) begin
			step();
			for (int k = 0; k < 2; k++) begin
				if (free[k] && n < rs_size) begin
					send_op(k, random_op(), pick_dep(), pick_dep(), 1'b0, t);
					n++;
				end
			end
		end
		wait_idle();
		check_count(n_done, done0 + rs_size, "batch after the flush");
		end_test(5, "flush", err0);

		err0 = errors;
		done0 = n_done;
		n = 0;
		while (n < 200) begin
			step();
			for (int k = 0; k < 2; k++) begin
				if (free[k] && n < 200 && (next_rand() & 32'd3) != 0) begin
					send_op(k, random_op(), pick_dep(), pick_dep(), 1'b0, t);
					if (t >= 0)
						n++;
				end
			end
			if (ext_tags.size() > 0 && (next_rand() & 32'd3) == 0) begin
				send_ext(ext_tags.pop_front());
			end else if (ext_tags.size() < 3 && (next_rand() & 32'd7) == 0) begin
				x = new_ext();
				if (x >= 0) begin
					ext_tags.push_back(x);
					recent.push_back(x);
				end
			end
		end
		while (ext_tags.size() > 0) begin
			step();
			send_ext(ext_tags.pop_front());
		end
		wait_idle();
		check_count(n_done, done0 + 200, "random mix");
		end_test(6, "random mix", err0);

		$display("tests: 6, failed: %0d, checks: %0d, errors: %0d",
		         failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
rtl/ooo_pkg.sv
rtl/operand_capture.sv
rtl/alu_rs.sv
rtl/rs_select.sv
rtl/alu_exec.sv
rtl/alu_cluster_top.sv
test/tb_alu_cluster.sv
